// ==== src/spi_defs.svh ====
//----------------------------------------------------------------------
// build-time constants for the spi master
// slave count, fifo depth and spi_clk divider
//----------------------------------------------------------------------
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

// ---------------------------------------------------------------------
// slave select
// ---------------------------------------------------------------------
// one cs_n line per slave
`define SPI_NUM_SLAVES 4

// ---------------------------------------------------------------------
// buffering and serial clock
// ---------------------------------------------------------------------
// entries per fifo, power of two only
`define SPI_FIFO_DEPTH 4

// sclk cycles per spi_clk half period
`define SPI_CLK_DIV 2

`endif

// ==== src/spi_pkg.sv ====
//----------------------------------------------------------------------
// shared types for the spi master
// lane mode enum, command and response structs
//----------------------------------------------------------------------
`default_nettype none

`include "spi_defs.svh"

package spi_pkg;

  // slave index width follows the chip select count
  localparam int SPI_SLV_W = $clog2(`SPI_NUM_SLAVES);

  // ---------------------------------------------------------------------
  // lane mode
  // ---------------------------------------------------------------------
  typedef enum logic {
    LANE_SINGLE = 1'b0,
    LANE_QUAD   = 1'b1
  } spi_lane_e;

  // ---------------------------------------------------------------------
  // host side payloads
  // ---------------------------------------------------------------------
  // one transfer request, 11 bits
  typedef struct packed {
    logic [SPI_SLV_W-1:0] slave;
    spi_lane_e            lane;
    logic [7:0]           tx_data;
  } spi_cmd_t;

  // one transfer result, 10 bits
  typedef struct packed {
    logic [SPI_SLV_W-1:0] slave;
    logic [7:0]           rx_data;
  } spi_rsp_t;

endpackage

`default_nettype wire

// ==== src/spi_xfer_fifo.sv ====
//----------------------------------------------------------------------
// synchronous fifo with valid/ready on both sides
// payload type set per instance
//----------------------------------------------------------------------
`default_nettype none

`include "spi_defs.svh"

module spi_xfer_fifo #(
  parameter type item_t = logic [7:0]
) (
  input  wire logic  sclk,
  input  wire logic  rst_n,
  input  wire item_t in_data,
  input  wire logic  in_valid,
  output logic       in_ready,
  output item_t      out_data,
  output logic       out_valid,
  input  wire logic  out_ready
);

  localparam int DEPTH = `SPI_FIFO_DEPTH;
  // depth is a power of two so pointers wrap by themselves
  localparam int PTR_W = $clog2(DEPTH);

  item_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  // ---------------------------------------------------------------------
  // handshake
  // ---------------------------------------------------------------------
  assign in_ready  = (count != (PTR_W + 1)'(DEPTH));
  assign out_valid = (count != '0);
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  // head entry, visible the cycle after its push
  assign out_data = mem[rd_ptr];

  // ---------------------------------------------------------------------
  // storage
  // ---------------------------------------------------------------------
  always_ff @(posedge sclk) begin
    if (push) mem[wr_ptr] <= in_data;
  end

  // ---------------------------------------------------------------------
  // pointers and occupancy
  // ---------------------------------------------------------------------
  always_ff @(posedge sclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      // simultaneous push and pop leaves count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/spi_host_port.sv ====
//----------------------------------------------------------------------
// host port of the spi master
// four-phase req/ack on the host side, valid/ready to the fifos
//----------------------------------------------------------------------
`default_nettype none

module spi_host_port (
  input  wire  logic              sclk,
  input  wire  logic              rst_n,
  input  wire  spi_pkg::spi_cmd_t cmd,
  input  wire  logic              cmd_req,
  output logic                    cmd_ack,
  output spi_pkg::spi_rsp_t       rsp,
  output logic                    rsp_req,
  input  wire  logic              rsp_ack,
  output spi_pkg::spi_cmd_t       push_data,
  output logic                    push_valid,
  input  wire  logic              push_ready,
  input  wire  spi_pkg::spi_rsp_t pop_data,
  input  wire  logic              pop_valid,
  output logic                    pop_ready
);
  import spi_pkg::*;

  typedef enum logic {CMD_IDLE, CMD_WAIT} cmd_state_e;
  typedef enum logic [1:0] {RSP_IDLE, RSP_REQ, RSP_DROP} rsp_state_e;

  cmd_state_e cmd_state;
  rsp_state_e rsp_state;
  spi_rsp_t   rsp_q;

  // ---------------------------------------------------------------------
  // command side
  // ---------------------------------------------------------------------
  // host holds cmd stable while req is high
  assign push_data  = cmd;
  // one push per req phase, only from idle
  assign push_valid = cmd_req && (cmd_state == CMD_IDLE);
  // ack follows the push, drops once req is gone
  assign cmd_ack    = (cmd_state == CMD_WAIT);

  always_ff @(posedge sclk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_state <= CMD_IDLE;
    end else if (cmd_state == CMD_IDLE) begin
      // full fifo keeps us here, ack withheld
      if (push_valid && push_ready) cmd_state <= CMD_WAIT;
    end else begin
      if (!cmd_req) cmd_state <= CMD_IDLE;
    end
  end

  // ---------------------------------------------------------------------
  // response side
  // ---------------------------------------------------------------------
  assign pop_ready = (rsp_state == RSP_IDLE);
  assign rsp_req   = (rsp_state == RSP_REQ);
  assign rsp       = rsp_q;

  always_ff @(posedge sclk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_state <= RSP_IDLE;
    end else begin
      case (rsp_state)
        RSP_IDLE: if (pop_valid) rsp_state <= RSP_REQ;
        RSP_REQ:  if (rsp_ack) rsp_state <= RSP_DROP;
        // wait for host to release ack before next pop
        RSP_DROP: if (!rsp_ack) rsp_state <= RSP_IDLE;
        default:  rsp_state <= RSP_IDLE;
      endcase
    end
  end

  // held for the whole handshake
  always_ff @(posedge sclk) begin
    if (pop_valid && pop_ready) rsp_q <= pop_data;
  end

endmodule

`default_nettype wire

// ==== src/spi_shift_engine.sv ====
//----------------------------------------------------------------------
// spi mode 0 shift engine
// spi_clk and chip select generation, one byte per command
// single lane or quad lane shifting, response push at end
//----------------------------------------------------------------------
`default_nettype none

`include "spi_defs.svh"

module spi_shift_engine (
  input  wire  logic                      sclk,
  input  wire  logic                      rst_n,
  input  wire  spi_pkg::spi_cmd_t         cmd_data,
  input  wire  logic                      cmd_valid,
  output logic                            cmd_ready,
  output spi_pkg::spi_rsp_t               rsp_data,
  output logic                            rsp_valid,
  input  wire  logic                      rsp_ready,
  output logic [`SPI_NUM_SLAVES-1:0]      cs_n,
  output logic                            spi_clk,
  output logic [3:0]                      mosi,
  input  wire  logic [3:0]                miso
);
  import spi_pkg::*;

  localparam int NUM_SLV = `SPI_NUM_SLAVES;
  localparam int CLK_DIV = `SPI_CLK_DIV;
  localparam int DIV_W   = $clog2(CLK_DIV + 1);

  typedef enum logic [1:0] {ST_IDLE, ST_SHIFT, ST_DONE} state_e;

  state_e               state;
  logic [DIV_W-1:0]     div_cnt;
  // spi_clk edges still to go, 16 single or 4 quad
  logic [4:0]           edges_left;
  logic [SPI_SLV_W-1:0] slave_q;
  spi_lane_e            lane_q;
  logic [7:0]           tx_q;
  logic [7:0]           rx_q;
  logic                 pop;
  logic                 half_done;
  logic                 last_edge;

  // ---------------------------------------------------------------------
  // handshakes
  // ---------------------------------------------------------------------
  // only take a command when the result has somewhere to go
  assign cmd_ready = (state == ST_IDLE) && rsp_ready;
  assign pop       = cmd_valid && cmd_ready;
  assign rsp_valid = (state == ST_DONE);
  assign rsp_data  = '{slave: slave_q, rx_data: rx_q};

  // end of a half period, spi_clk toggles here
  assign half_done = (state == ST_SHIFT) && (div_cnt == DIV_W'(CLK_DIV - 1));
  // final toggle is always a falling edge
  assign last_edge = half_done && (edges_left == 5'd1);

  // ---------------------------------------------------------------------
  // fsm
  // ---------------------------------------------------------------------
  always_ff @(posedge sclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:  if (pop) state <= ST_SHIFT;
        ST_SHIFT: if (last_edge) state <= ST_DONE;
        // push cycle, then one idle cycle before next pop
        ST_DONE:  if (rsp_ready) state <= ST_IDLE;
        default:  state <= ST_IDLE;
      endcase
    end
  end

  // ---------------------------------------------------------------------
  // pins and divider
  // ---------------------------------------------------------------------
  always_ff @(posedge sclk or negedge rst_n) begin
    if (!rst_n) begin
      cs_n       <= '1;
      spi_clk    <= 1'b0;
      mosi       <= '0;
      div_cnt    <= '0;
      edges_left <= '0;
    end else if (pop) begin
      // select goes low, first bits set up with it
      cs_n       <= ~(NUM_SLV'(1) << cmd_data.slave);
      spi_clk    <= 1'b0;
      div_cnt    <= '0;
      if (cmd_data.lane == LANE_QUAD) begin
        edges_left <= 5'd4;
        mosi       <= cmd_data.tx_data[7:4];
      end else begin
        edges_left <= 5'd16;
        mosi       <= {3'b000, cmd_data.tx_data[7]};
      end
    end else if (half_done) begin
      div_cnt    <= '0;
      spi_clk    <= ~spi_clk;
      edges_left <= edges_left - 1'b1;
      if (last_edge) begin
        // deselect right on the last falling edge
        cs_n <= '1;
        mosi <= '0;
      end else if (spi_clk) begin
        // falling edge, next bits from the shifter
        if (lane_q == LANE_QUAD) mosi <= tx_q[3:0];
        else mosi <= {3'b000, tx_q[6]};
      end
    end else if (state == ST_SHIFT) begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // ---------------------------------------------------------------------
  // shift registers
  // ---------------------------------------------------------------------
  always_ff @(posedge sclk) begin
    if (pop) begin
      slave_q <= cmd_data.slave;
      lane_q  <= cmd_data.lane;
      tx_q    <= cmd_data.tx_data;
    end else if (half_done) begin
      if (!spi_clk) begin
        // rising edge, sample miso msb first
        if (lane_q == LANE_QUAD) rx_q <= {rx_q[3:0], miso};
        else rx_q <= {rx_q[6:0], miso[0]};
      end else begin
        // falling edge, drop the bits just sent
        if (lane_q == LANE_QUAD) tx_q <= {tx_q[3:0], 4'h0};
        else tx_q <= {tx_q[6:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/spi_master_top.sv ====
//----------------------------------------------------------------------
// spi master top level
// host port, command and response fifos, shift engine
//----------------------------------------------------------------------
`default_nettype none

`include "spi_defs.svh"

module spi_master_top (
  input  wire  logic                 sclk,
  input  wire  logic                 rst_n,
  input  wire  spi_pkg::spi_cmd_t    cmd,
  input  wire  logic                 cmd_req,
  output logic                       cmd_ack,
  output spi_pkg::spi_rsp_t          rsp,
  output logic                       rsp_req,
  input  wire  logic                 rsp_ack,
  output logic [`SPI_NUM_SLAVES-1:0] cs_n,
  output logic                       spi_clk,
  output logic [3:0]                 mosi,
  input  wire  logic [3:0]           miso
);
  import spi_pkg::*;

  // command path, host port to engine
  spi_cmd_t cmd_push_data;
  logic     cmd_push_valid;
  logic     cmd_push_ready;
  spi_cmd_t cmd_pop_data;
  logic     cmd_pop_valid;
  logic     cmd_pop_ready;
  // response path, engine back to host port
  spi_rsp_t rsp_push_data;
  logic     rsp_push_valid;
  logic     rsp_push_ready;
  spi_rsp_t rsp_pop_data;
  logic     rsp_pop_valid;
  logic     rsp_pop_ready;

  spi_host_port u_host_port (
    .sclk, .rst_n, .cmd, .cmd_req, .cmd_ack, .rsp, .rsp_req, .rsp_ack,
    .push_data (cmd_push_data),  .push_valid (cmd_push_valid), .push_ready (cmd_push_ready),
    .pop_data  (rsp_pop_data),   .pop_valid  (rsp_pop_valid),  .pop_ready  (rsp_pop_ready)
  );

  spi_xfer_fifo #(.item_t(spi_cmd_t)) u_cmd_fifo (
    .sclk, .rst_n,
    .in_data  (cmd_push_data), .in_valid  (cmd_push_valid), .in_ready  (cmd_push_ready),
    .out_data (cmd_pop_data),  .out_valid (cmd_pop_valid),  .out_ready (cmd_pop_ready)
  );

  spi_xfer_fifo #(.item_t(spi_rsp_t)) u_rsp_fifo (
    .sclk, .rst_n,
    .in_data  (rsp_push_data), .in_valid  (rsp_push_valid), .in_ready  (rsp_push_ready),
    .out_data (rsp_pop_data),  .out_valid (rsp_pop_valid),  .out_ready (rsp_pop_ready)
  );

  spi_shift_engine u_shift_engine (
    .sclk, .rst_n, .cs_n, .spi_clk, .mosi, .miso,
    .cmd_data (cmd_pop_data),  .cmd_valid (cmd_pop_valid),  .cmd_ready (cmd_pop_ready),
    .rsp_data (rsp_push_data), .rsp_valid (rsp_push_valid), .rsp_ready (rsp_push_ready)
  );

endmodule

`default_nettype wire

// ==== tests/tb_spi_master.sv ====
//----------------------------------------------------------------------
// testbench for the spi master
// clock, reset, spi slave model, directed tests and compare tasks
//----------------------------------------------------------------------
`default_nettype none

`include "spi_defs.svh"

module tb_spi_master;
  import spi_pkg::*;

  localparam int NUM_SLV    = `SPI_NUM_SLAVES;
  localparam int DEPTH      = `SPI_FIFO_DEPTH;
  // both fifos full plus one response held at the host port
  localparam int BP_CAP     = 2 * DEPTH + 1;
  localparam int BP_CMDS    = BP_CAP + 1;
  // single lane transfer with handshakes stays well inside this
  localparam int XFER_CYC   = 50;
  localparam int STALL_WAIT = 100;
  // 4 single, 4 quad, 6 burst, up to 10 back-pressure transfers
  localparam int NUM_XFERS  = 24;
  localparam int TIMEOUT    = NUM_XFERS * XFER_CYC + STALL_WAIT + 700;

  logic               sclk = 1'b0;
  logic               rst_n;
  spi_cmd_t           cmd;
  logic               cmd_req;
  logic               cmd_ack;
  spi_rsp_t           rsp;
  logic               rsp_req;
  logic               rsp_ack;
  logic [NUM_SLV-1:0] cs_n;
  logic               spi_clk;
  logic [3:0]         mosi;
  logic [3:0]         miso;

  int errors = 0;
  int checks = 0;
  int cycles = 0;

  // expectations per transfer, in command order
  spi_rsp_t           exp_rsp [$];
  logic [7:0]         exp_tx [$];
  logic [NUM_SLV-1:0] exp_cs [$];

  // ---------------------------------------------------------------------
  // clock, dut, timeout
  // ---------------------------------------------------------------------
  always #10 sclk = ~sclk;

  spi_master_top u_spi_master_top (
    .sclk, .rst_n, .cmd, .cmd_req, .cmd_ack, .rsp, .rsp_req, .rsp_ack,
    .cs_n, .spi_clk, .mosi, .miso
  );

  always @(posedge sclk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("ERROR: run did not finish within %0d cycles", TIMEOUT);
      $display("checks %0d, errors %0d", checks, errors + 1);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // ---------------------------------------------------------------------
  // spi slave model
  // ---------------------------------------------------------------------
  logic [7:0]         reply [NUM_SLV];
  spi_lane_e          lane_ann [$];
  spi_lane_e          cur_lane;
  logic [7:0]         out_sr;
  logic [7:0]         cap_sr;
  logic [NUM_SLV-1:0] cs_seen;
  logic [7:0]         cap_q [$];
  logic [NUM_SLV-1:0] cs_q [$];
  logic               sel_any;

  assign sel_any = ~&cs_n;

  // lowest selected slave, multiple selects show up in check_cs
  function automatic int sel_index(input logic [NUM_SLV-1:0] cs);
    int idx;
    idx = 0;
    for (int i = NUM_SLV - 1; i >= 0; i--) begin
      if (!cs[i]) idx = i;
    end
    return idx;
  endfunction

  // next bits onto miso, msb first
  task automatic shift_out();
    if (cur_lane == LANE_QUAD) begin
      miso   <= out_sr[7:4];
      out_sr = out_sr << 4;
    end else begin
      miso   <= {3'b000, out_sr[7]};
      out_sr = out_sr << 1;
    end
  endtask

  always @(posedge sel_any) begin
    if (rst_n) begin
      cs_seen = cs_n;
      cap_sr  = '0;
      if (lane_ann.size() == 0) begin
        errors++;
        $display("ERROR: chip select went low with no transfer pending");
        cur_lane = LANE_SINGLE;
      end else begin
        cur_lane = lane_ann.pop_front();
      end
      out_sr = reply[sel_index(cs_n)];
      shift_out();
    end
  end

  always @(negedge spi_clk) begin
    if (sel_any === 1'b1) shift_out();
  end

  // mosi is stable at rising spi_clk
  always @(posedge spi_clk) begin
    if (sel_any === 1'b1) begin
      if (cur_lane == LANE_QUAD) cap_sr = {cap_sr[3:0], mosi};
      else cap_sr = {cap_sr[6:0], mosi[0]};
    end
  end

  always @(negedge sel_any) begin
    if (rst_n) begin
      cap_q.push_back(cap_sr);
      cs_q.push_back(cs_seen);
    end
  end

  // ---------------------------------------------------------------------
  // compare tasks
  // ---------------------------------------------------------------------
  task automatic check_rsp(input string name, input spi_rsp_t exp, input spi_rsp_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: expected slave %0d rx %02h, actual slave %0d rx %02h",
               name, exp.slave, exp.rx_data, act.slave, act.rx_data);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: expected mosi byte %02h, actual %02h", name, exp, act);
    end
  endtask

  task automatic check_cs(input string name, input logic [NUM_SLV-1:0] exp,
                          input logic [NUM_SLV-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: expected cs_n %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // ---------------------------------------------------------------------
  // host side handshakes
  // ---------------------------------------------------------------------
  function automatic spi_cmd_t make_cmd(input int slave, input spi_lane_e lane,
                                        input logic [7:0] tx);
    spi_cmd_t c;
    c.slave   = SPI_SLV_W'(slave);
    c.lane    = lane;
    c.tx_data = tx;
    return c;
  endfunction

  // record what the slave and host should see, announce the lane
  task automatic expect_xfer(input spi_cmd_t c);
    spi_rsp_t           r;
    logic [NUM_SLV-1:0] sel;
    r.slave      = c.slave;
    r.rx_data    = reply[c.slave];
    sel          = '1;
    sel[c.slave] = 1'b0;
    exp_rsp.push_back(r);
    exp_tx.push_back(c.tx_data);
    exp_cs.push_back(sel);
    lane_ann.push_back(c.lane);
  endtask

  task automatic release_cmd();
    cmd_req <= 1'b0;
    do @(posedge sclk); while (cmd_ack);
  endtask

  // req stays high when no ack comes within limit
  task automatic send_cmd(input spi_cmd_t c, input int limit, output bit acked);
    int waited;
    waited  = 0;
    acked   = 1'b0;
    cmd     <= c;
    cmd_req <= 1'b1;
    while (!acked && waited < limit) begin
      @(posedge sclk);
      acked = cmd_ack;
      waited++;
    end
    if (acked) release_cmd();
  endtask

  task automatic take_rsp(output spi_rsp_t r);
    do @(posedge sclk); while (!rsp_req);
    r = rsp;
    rsp_ack <= 1'b1;
    do @(posedge sclk); while (rsp_req);
    rsp_ack <= 1'b0;
  endtask

  task automatic issue(input string name, input spi_cmd_t c);
    bit acked;
    expect_xfer(c);
    send_cmd(c, STALL_WAIT, acked);
    if (!acked) begin
      errors++;
      $display("ERROR %s: command was never acknowledged", name);
      cmd_req <= 1'b0;
    end
  endtask

  // one response plus what the slave saw on the pins
  task automatic finish_xfer(input string name);
    spi_rsp_t r;
    take_rsp(r);
    check_rsp(name, exp_rsp.pop_front(), r);
    if (cap_q.size() == 0) begin
      errors++;
      $display("ERROR %s: no transfer was seen on the spi pins", name);
    end else begin
      check_byte(name, exp_tx.pop_front(), cap_q.pop_front());
      check_cs(name, exp_cs.pop_front(), cs_q.pop_front());
    end
  endtask

  function automatic logic [7:0] rand_byte();
    return 8'($urandom());
  endfunction

  // ---------------------------------------------------------------------
  // directed tests
  // ---------------------------------------------------------------------
  task automatic test_reset();
    check_cs("test_reset cs_n", '1, cs_n);
    check_bit("test_reset spi_clk", 1'b0, spi_clk);
    check_bit("test_reset cmd_ack", 1'b0, cmd_ack);
    check_bit("test_reset rsp_req", 1'b0, rsp_req);
  endtask

  task automatic test_single_lane();
    for (int s = 0; s < NUM_SLV; s++) begin
      reply[s] = rand_byte();
      issue("test_single_lane", make_cmd(s, LANE_SINGLE, rand_byte()));
      finish_xfer("test_single_lane");
    end
  endtask

  task automatic test_quad_lane();
    int s;
    for (int i = 0; i < 4; i++) begin
      s        = $urandom_range(NUM_SLV - 1, 0);
      reply[s] = rand_byte();
      issue("test_quad_lane", make_cmd(s, LANE_QUAD, rand_byte()));
      finish_xfer("test_quad_lane");
    end
  endtask

  // all six queued before any response is taken
  task automatic test_burst();
    for (int s = 0; s < NUM_SLV; s++) reply[s] = rand_byte();
    for (int i = 0; i < 6; i++) begin
      issue("test_burst", make_cmd($urandom_range(NUM_SLV - 1, 0),
                                   (i % 2) ? LANE_QUAD : LANE_SINGLE, rand_byte()));
    end
    repeat (6) finish_xfer("test_burst");
  endtask

  task automatic test_backpressure();
    spi_cmd_t c;
    bit       acked;
    int       n_acked;
    int       total;
    n_acked = 0;
    acked   = 1'b1;
    for (int s = 0; s < NUM_SLV; s++) reply[s] = rand_byte();
    // no rsp_ack yet, so the pipeline fills up
    while (acked && n_acked < BP_CMDS) begin
      c = make_cmd($urandom_range(NUM_SLV - 1, 0), spi_lane_e'($urandom_range(1, 0)),
                   rand_byte());
      expect_xfer(c);
      send_cmd(c, STALL_WAIT, acked);
      if (acked) n_acked++;
    end
    checks++;
    if (acked) begin
      errors++;
      $display("ERROR test_backpressure: cmd_ack never stalled");
    end else if (n_acked != BP_CAP) begin
      errors++;
      $display("FAIL test_backpressure: expected %0d accepted, actual %0d", BP_CAP, n_acked);
    end
    total = acked ? n_acked : n_acked + 1;
    fork
      begin
        // stalled command goes in once responses drain
        if (!acked) begin
          while (!cmd_ack) @(posedge sclk);
          release_cmd();
        end
      end
      begin
        repeat (total) finish_xfer("test_backpressure");
      end
    join
  endtask

  // ---------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------
  initial begin
    void'($urandom(32'h6073_7b2c));
    rst_n   = 1'b0;
    cmd     = '0;
    cmd_req = 1'b0;
    rsp_ack = 1'b0;
    miso    = 4'h0;
    repeat (4) @(posedge sclk);
    rst_n <= 1'b1;
    @(posedge sclk);
    test_reset();
    test_single_lane();
    test_quad_lane();
    test_burst();
    test_backpressure();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== spi_master_top.f ====
+incdir+src
src/spi_pkg.sv
src/spi_xfer_fifo.sv
src/spi_host_port.sv
src/spi_shift_engine.sv
src/spi_master_top.sv
tests/tb_spi_master.sv
